// File: common/rv32i_pkg.sv
package rv32i_pkg;

    // Fetch start address
    localparam logic [31:0] RESET_PC = 32'h1eceb000;

    localparam int XLEN = 32;

    // Cache line and memory beat geometry
    localparam int LINE_BITS      = 256;
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = 4;

    // Direct-mapped icache with 32-byte lines
    localparam int ICACHE_SETS = 16;
    localparam int OFFSET_BITS = 5;
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = 23;

    // Instruction queue
    localparam int QUEUE_DEPTH = 16;
    localparam int QPTR_BITS   = 4;

endpackage : rv32i_pkg

// File: common/cache_ufp_if.sv
`timescale 1ns/1ps

interface cache_ufp_if
import rv32i_pkg::*;
();

    logic   [XLEN-1:0]  addr;
    logic   [3:0]       rmask;      // Nonzero for one cycle per request
    logic   [XLEN-1:0]  rdata;
    logic               resp;

    modport fetch (
        output  addr, rmask,
        input   rdata, resp
    );

    modport cache (
        input   addr, rmask,
        output  rdata, resp
    );

endinterface : cache_ufp_if

// File: common/cache_dfp_if.sv
`timescale 1ns/1ps

interface cache_dfp_if
import rv32i_pkg::*;
();

    logic   [XLEN-1:0]      addr;
    logic                   read;       // Level, held until resp
    logic   [LINE_BITS-1:0] rdata;
    logic                   resp;       // One-cycle pulse with full line

    modport cache (
        output  addr, read,
        input   rdata, resp
    );

    modport adapter (
        input   addr, read,
        output  rdata, resp
    );

endinterface : cache_dfp_if

// File: icache/icache.sv
`timescale 1ns/1ps

module icache
import rv32i_pkg::*;
(
    input   logic           clk,
    input   logic           rst,

    cache_ufp_if.cache      ufp,
    cache_dfp_if.cache      dfp
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPARE,
        S_FILL
    } state_t;

    state_t                 state, next_state;

    logic   [TAG_BITS-1:0]  tag_arr   [ICACHE_SETS];
    logic   [LINE_BITS-1:0] data_arr  [ICACHE_SETS];
    logic   [ICACHE_SETS-1:0] valid_arr;

    logic   [XLEN-1:0]      req_addr;   // Held for the whole request
    logic   [TAG_BITS-1:0]  req_tag;
    logic   [INDEX_BITS-1:0] req_index;
    logic   [2:0]           req_word;
    logic                   hit;
    logic                   fill_en;
    logic   [LINE_BITS-1:0] sel_line;

    assign req_tag   = req_addr[XLEN-1 -: TAG_BITS];
    assign req_index = req_addr[OFFSET_BITS +: INDEX_BITS];
    assign req_word  = req_addr[OFFSET_BITS-1:2];

    assign hit      = valid_arr[req_index] && (tag_arr[req_index] == req_tag);
    assign sel_line = data_arr[req_index];

    assign ufp.rdata = sel_line[req_word*XLEN +: XLEN];
    assign dfp.addr  = {req_addr[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};  // Line aligned

    always_comb begin
        next_state = state;
        ufp.resp   = 1'b0;
        dfp.read   = 1'b0;
        fill_en    = 1'b0;

        unique case (state)
            S_IDLE: begin
                if (|ufp.rmask) begin
                    next_state = S_COMPARE;
                end
            end
            S_COMPARE: begin
                if (hit) begin
                    ufp.resp   = 1'b1;
                    next_state = S_IDLE;
                end else begin
                    dfp.read   = 1'b1;      // Miss goes straight to memory
                    next_state = S_FILL;
                end
            end
            S_FILL: begin
                dfp.read = 1'b1;
                if (dfp.resp) begin
                    fill_en    = 1'b1;
                    next_state = S_COMPARE; // Re-check the freshly filled line
                end
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            valid_arr <= '0;
        end else begin
            state <= next_state;
            if (fill_en) begin
                valid_arr[req_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && |ufp.rmask) begin
            req_addr <= ufp.addr;
        end
        if (fill_en) begin
            tag_arr[req_index]  <= req_tag;
            data_arr[req_index] <= dfp.rdata;
        end
    end

endmodule : icache

// File: design/cacheline_adapter.sv
`timescale 1ns/1ps

module cacheline_adapter
import rv32i_pkg::*;
(
    input   logic               clk,
    input   logic               rst,

    cache_dfp_if.adapter        dfp,

    output  logic   [XLEN-1:0]      bmem_addr_o,
    output  logic                   bmem_read_o,
    input   logic   [BEAT_BITS-1:0] bmem_rdata_i,
    input   logic                   bmem_rvalid_i
);

    logic                           read_q;
    logic   [XLEN-1:0]              addr_q;
    logic   [LINE_BITS-1:0]         line_q;
    logic   [$clog2(BEATS_PER_LINE)-1:0] beat_cnt;
    logic                           resp_q;
    logic                           last_beat;

    assign bmem_read_o = dfp.read && !read_q;   // Rising edge of fill request
    assign bmem_addr_o = bmem_read_o ? dfp.addr : addr_q;

    assign last_beat = bmem_rvalid_i && (beat_cnt == BEATS_PER_LINE - 1);

    assign dfp.rdata = line_q;
    assign dfp.resp  = resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_q   <= 1'b0;
            beat_cnt <= '0;
            resp_q   <= 1'b0;
        end else begin
            read_q <= dfp.read;
            resp_q <= last_beat;
            if (bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1;    // Wraps after the fourth beat
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bmem_read_o) begin
            addr_q <= bmem_addr_o;
        end
        // Lowest beat ends up at the bottom of the line
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

endmodule : cacheline_adapter

// File: design/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc
import rv32i_pkg::*;
(
    input   logic           clk,
    input   logic           rst,

    input   logic           stall_i,
    input   logic           bmem_ready_i,

    cache_ufp_if.fetch      ufp
);

    logic   [XLEN-1:0]  pc;
    logic               ready_flag;     // No request outstanding
    logic               issue;

    // Hold off while the queue is nearly full or memory is busy
    assign issue = ready_flag && !stall_i && bmem_ready_i;

    assign ufp.addr  = pc;
    assign ufp.rmask = issue ? 4'b1111 : 4'b0000;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_PC;
            ready_flag <= 1'b1;
        end else begin
            if (ufp.resp) begin
                pc         <= pc + 32'd4;
                ready_flag <= 1'b1;
            end else if (issue) begin
                ready_flag <= 1'b0;
            end
        end
    end

endmodule : fetch_pc

// File: design/inst_queue.sv
`timescale 1ns/1ps

module inst_queue
import rv32i_pkg::*;
(
    input   logic               clk,
    input   logic               rst,

    input   logic   [XLEN-1:0]  wdata_i,
    input   logic               enqueue_i,
    input   logic               dequeue_i,
    output  logic   [XLEN-1:0]  rdata_o,
    output  logic               stall_o,
    output  logic               empty_o
);

    logic   [XLEN-1:0]      mem [QUEUE_DEPTH];
    logic   [QPTR_BITS-1:0] wr_ptr, rd_ptr;
    logic   [QPTR_BITS:0]   count;
    logic                   do_enq, do_deq;

    assign do_deq = dequeue_i && (count != '0);         // Pop on empty is dropped
    assign do_enq = enqueue_i && (count != QUEUE_DEPTH);

    assign rdata_o = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign stall_o = (count >= QUEUE_DEPTH - 1);        // Room left for one in-flight word

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

endmodule : inst_queue

// File: design/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend
import rv32i_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst,

    output  logic   [XLEN-1:0]      bmem_addr_o,
    output  logic                   bmem_read_o,
    input   logic                   bmem_ready_i,
    input   logic   [BEAT_BITS-1:0] bmem_rdata_i,
    input   logic                   bmem_rvalid_i,

    output  logic   [XLEN-1:0]      inst_o,
    output  logic                   inst_valid_o,
    input   logic                   dequeue_i
);

    logic   queue_stall;
    logic   queue_empty;

    cache_ufp_if ufp_bus ();
    cache_dfp_if dfp_bus ();

    assign inst_valid_o = !queue_empty;

    fetch_pc fetch_pc_i (
        .clk          (clk),
        .rst          (rst),
        .stall_i      (queue_stall),
        .bmem_ready_i (bmem_ready_i),
        .ufp          (ufp_bus.fetch)
    );

    icache icache_i (
        .clk (clk),
        .rst (rst),
        .ufp (ufp_bus.cache),
        .dfp (dfp_bus.cache)
    );

    cacheline_adapter adapter_i (
        .clk           (clk),
        .rst           (rst),
        .dfp           (dfp_bus.adapter),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    // Every cache response lands in the queue
    inst_queue inst_queue_i (
        .clk       (clk),
        .rst       (rst),
        .wdata_i   (ufp_bus.rdata),
        .enqueue_i (ufp_bus.resp),
        .dequeue_i (dequeue_i),
        .rdata_o   (inst_o),
        .stall_o   (queue_stall),
        .empty_o   (queue_empty)
    );

endmodule : fetch_frontend

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output  logic   clk_o,
    output  logic   rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;      // 4 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule : tb_clock_gen

// File: testbench/fetch_frontend_assert.sv
`timescale 1ns/1ps

module fetch_frontend_assert
import rv32i_pkg::*;
(
    input   logic               clk,
    input   logic               rst,
    input   logic   [XLEN-1:0]  bmem_addr_o,
    input   logic               bmem_read_o,
    input   logic               inst_valid_o
);

    int fail_count = 0;

    read_single_pulse: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |=> !bmem_read_o)
        else begin
            $error("bmem_read_o high two cycles in a row");
            fail_count++;
        end

    read_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> (bmem_addr_o[OFFSET_BITS-1:0] == '0))
        else begin
            $error("bmem_addr_o not line aligned");
            fail_count++;
        end

    // Queue is empty right after any reset cycle
    valid_low_after_rst: assert property (@(posedge clk)
        rst |=> !inst_valid_o)
        else begin
            $error("inst_valid_o high after reset");
            fail_count++;
        end

endmodule : fetch_frontend_assert

bind fetch_frontend fetch_frontend_assert fetch_frontend_assert_i (.*);

// File: testbench/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend
import rv32i_pkg::*;
();

    logic                   clk, rst, rst_gen, rst_extra;
    logic   [XLEN-1:0]      bmem_addr_o;
    logic                   bmem_read_o, bmem_ready_i, bmem_rvalid_i;
    logic   [BEAT_BITS-1:0] bmem_rdata_i;
    logic   [XLEN-1:0]      inst_o;
    logic                   inst_valid_o, dequeue_i;

    integer                 seed = 9;
    int                     pulse_count, total_errors, checks;
    bit                     mem_busy;
    logic   [XLEN-1:0]      exp_pc;
    logic   [XLEN-1:0]      read_log [$];

    assign rst = rst_gen | rst_extra;

    tb_clock_gen clock_gen_i (.clk_o(clk), .rst_o(rst_gen));

    fetch_frontend DUT (.*);

    function automatic logic [XLEN-1:0] expected_word(input logic [XLEN-1:0] a);
        return a ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [XLEN-1:0] line_of(input logic [XLEN-1:0] a);
        return {a[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    // Burst memory returning four beats per read pulse
    always begin
        logic [XLEN-1:0] base;
        int              lat;
        @(posedge clk);
        #1;
        if (bmem_read_o) begin
            base = bmem_addr_o;
            pulse_count++;
            read_log.push_back(base);
            mem_busy = 1'b1;
            lat = 2 + ($unsigned($random(seed)) % 6);
            repeat (lat) @(posedge clk);
            for (int k = 0; k < BEATS_PER_LINE; k++) begin
                #1;
                bmem_rdata_i  = {expected_word(base + 8*k + 4), expected_word(base + 8*k)};
                bmem_rvalid_i = 1'b1;
                @(posedge clk);
                #1 bmem_rvalid_i = 1'b0;
                repeat ($unsigned($random(seed)) % 3) @(posedge clk);
                if (k < BEATS_PER_LINE - 1) @(posedge clk);
            end
            mem_busy = 1'b0;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s at %0t", msg, $time);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!inst_valid_o) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 2000) abort_run("Timed out waiting for inst_valid_o");
        end
    endtask

    task automatic pop_and_check();
        wait_valid();
        checks++;
        if (inst_o !== expected_word(exp_pc)) begin
            $display("FAILED at %0t: pc %h got %h expected %h",
                     $time, exp_pc, inst_o, expected_word(exp_pc));
            total_errors++;
        end
        exp_pc = exp_pc + 4;
        dequeue_i = 1'b1;
        @(posedge clk);
        #1 dequeue_i = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s: %s", name, (total_errors == errs_before) ? "ok" : "errors");
    endtask

    initial begin
        int errs, n, snap, lines;
        dequeue_i     = 1'b0;
        bmem_ready_i  = 1'b1;
        bmem_rvalid_i = 1'b0;
        bmem_rdata_i  = '0;
        rst_extra     = 1'b0;
        exp_pc        = RESET_PC;
        n = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > 100) abort_run("Reset never released");
        end
        @(posedge clk);
        #1;

        errs = total_errors;
        repeat (64) pop_and_check();
        report_test("test 1 sequential fetch", errs);

        errs = total_errors;
        lines = 0;
        foreach (read_log[i]) begin
            if (read_log[i] >= line_of(RESET_PC) && read_log[i] <= line_of(RESET_PC + 4*63))
                lines++;
        end
        checks++;
        if (lines != (line_of(RESET_PC + 4*63) - line_of(RESET_PC)) / 32 + 1) begin
            $display("FAILED at %0t: %0d fills for first 64 words", $time, lines);
            total_errors++;
        end
        report_test("test 2 line fills", errs);

        errs = total_errors;
        wait_valid();
        snap = 0;
        for (int c = 0; c < 200; c++) begin
            if (c == 120) snap = pulse_count;
            checks++;
            if (!inst_valid_o) begin
                $display("FAILED at %0t: inst_valid_o dropped while stalled", $time);
                total_errors++;
            end
            @(posedge clk);
            #1;
        end
        checks++;
        if (pulse_count != snap) begin
            $display("FAILED at %0t: read pulse while queue full", $time);
            total_errors++;
        end
        repeat (20) pop_and_check();
        report_test("test 3 back-pressure", errs);

        errs = total_errors;
        bmem_ready_i = 1'b0;
        repeat (3) @(posedge clk);
        #1 snap = pulse_count;
        for (int c = 0; c < 100; c++) begin
            if (inst_valid_o) pop_and_check();
            else begin
                @(posedge clk);
                #1;
            end
        end
        checks++;
        if (pulse_count != snap) begin
            $display("FAILED at %0t: read pulse while bmem not ready", $time);
            total_errors++;
        end
        bmem_ready_i = 1'b1;
        repeat (32) pop_and_check();
        report_test("test 4 bmem not ready", errs);

        errs = total_errors;
        bmem_ready_i = 1'b0;
        repeat (10) @(posedge clk);
        n = 0;
        while (mem_busy) begin
            @(posedge clk);
            n++;
            if (n > 200) abort_run("Memory model never went idle");
        end
        repeat (5) @(posedge clk);
        #1 rst_extra = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst_extra = 1'b0;
        exp_pc = RESET_PC;
        bmem_ready_i = 1'b1;
        repeat (8) pop_and_check();
        report_test("test 5 reset mid-run", errs);

        total_errors = total_errors + DUT.fetch_frontend_assert_i.fail_count;
        $display("Checks: %0d, errors: %0d", checks, total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_fetch_frontend

// File: fetch_frontend.f
common/rv32i_pkg.sv
common/cache_ufp_if.sv
common/cache_dfp_if.sv
icache/icache.sv
design/cacheline_adapter.sv
design/fetch_pc.sv
design/inst_queue.sv
design/fetch_frontend.sv
testbench/tb_clock_gen.sv
testbench/fetch_frontend_assert.sv
testbench/tb_fetch_frontend.sv
